// ==== dv/mdu_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module mdu_assertions
	import mdu_pkg::*;
#(
	parameter int STAGES = MDU_STAGES_DEFAULT
) (
	input logic clk,
	input logic rst,
	input logic start,
	input logic kill,
	input logic done,
	input logic busy
);

	// prep register, the stages, then the hi/lo register
	localparam int LATENCY = STAGES + 2;

	property p_done_after_issue;
		@(posedge clk) disable iff (!rst)
			done |-> $past(start && !kill, LATENCY);
	endproperty

	a_done_latency: assert property (p_done_after_issue)
		else $error("done without an accepted issue %0d cycles before", LATENCY);

	// pipe is empty right after reset
	a_idle_after_reset: assert property (@(posedge clk) $rose(rst) |-> !busy)
		else $error("busy high in the first cycle after reset");

	a_done_while_busy: assert property (@(posedge clk) disable iff (!rst) done |-> busy)
		else $error("done high while busy is low");

endmodule

`default_nettype wire

// ==== dv/mdu_stim.txt ====
# issue <op> <a> <b> <kill> <chain> <mul_out>, all hex, chain 1 = no gap, mul_out used for MUL
# move <hi|lo> <value> and check <hi> <lo>, both wait until busy is low
# signed and unsigned products
issue 0 fffffffe 00000003 0 0 00000000
check ffffffff fffffffa
issue 1 ffffffff ffffffff 0 0 00000000
check fffffffe 00000001
issue 0 80000000 80000000 0 0 00000000
check 40000000 00000000
issue 0 7fffffff 80000000 0 0 00000000
check c0000000 80000000
issue 1 80000000 00000002 0 0 00000000
check 00000001 00000000
# back to back accumulate and subtract
issue 1 00010000 00010000 0 0 00000000
issue 5 ffffffff 00000002 0 1 00000000
issue 4 ffffffff 00000002 0 1 00000000
issue 6 00000003 fffffffd 0 1 00000000
issue 7 00000010 00000010 0 1 00000000
check 00000002 ffffff05
# wrap modulo 2^64
issue 0 00000000 00000005 0 0 00000000
issue 7 00000001 00000001 0 1 00000000
issue 4 00000001 00000003 0 1 00000000
check 00000000 00000002
# three operand mul leaves hi/lo alone
issue 8 fffffff9 00000006 0 0 ffffffd6
issue 8 00012345 00010000 0 1 23450000
check 00000000 00000002
# moves, then accumulate onto them
move hi 12345678
check 12345678 00000002
move lo 9abcdef0
check 12345678 9abcdef0
issue 5 00000010 00000010 0 0 00000000
check 12345678 9abcdff0
issue 5 ffffffff ffffffff 0 0 00000000
check 12345678 9abcdff1
move lo ffffffff
issue 4 00000001 00000001 0 0 00000000
check 12345679 00000000
# killed issues
issue 0 00000007 00000007 1 0 00000000
check 12345679 00000000
issue 5 00000002 00000003 0 0 00000000
issue 1 ffffffff ffffffff 1 1 00000000
check 12345679 00000006

// ==== dv/mdu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mdu_tb
	import mdu_pkg::*;
;

	localparam int STAGES  = 4;
	localparam int LATENCY = STAGES + 2;  // issue edge to done sample

	logic    clk;
	logic    rst;
	logic    start;
	logic    kill;
	mdu_op_t op;
	word_t   a;
	word_t   b;
	logic    hilo_wr;
	logic    hilo_wr_hi;
	word_t   wdata;
	logic    rd_hi;
	word_t   hilo_out;
	word_t   mul_out;
	logic    done;
	logic    busy;

	integer  seed = 52;
	longint  cyc = 0;          // clock edges seen
	longint  wd_limit_ns = 0;

	// parsed stimulus records
	string       kind_q [$];
	logic [31:0] f0_q [$];
	logic [31:0] f1_q [$];
	logic [31:0] f2_q [$];
	logic [31:0] f3_q [$];
	logic [31:0] f4_q [$];
	logic [31:0] f5_q [$];

	// completions still in flight in issue order
	mdu_op_t exp_op_q [$];
	word_t   exp_mul_q [$];
	longint  exp_cyc_q [$];

	mdu_top #(
		.STAGES(STAGES)
	) uut (
		.clk        (clk),
		.rst        (rst),
		.start      (start),
		.kill       (kill),
		.op         (op),
		.a          (a),
		.b          (b),
		.hilo_wr    (hilo_wr),
		.hilo_wr_hi (hilo_wr_hi),
		.wdata      (wdata),
		.rd_hi      (rd_hi),
		.hilo_out   (hilo_out),
		.mul_out    (mul_out),
		.done       (done),
		.busy       (busy)
	);

	bind mdu_top mdu_assertions #(
		.STAGES(STAGES)
	) u_sva (
		.clk   (clk),
		.rst   (rst),
		.start (start),
		.kill  (kill),
		.done  (done),
		.busy  (busy)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic compare_word(input word_t got, input word_t exp, input string what);
		if (got !== exp) begin
			stop_with_failure($sformatf("FAIL %0t: %s is %08h, expected %08h",
				$time, what, got, exp));
		end
	endtask

	task automatic compare_hilo(input dword_t got, input dword_t exp, input string what);
		if (got !== exp) begin
			stop_with_failure($sformatf("FAIL %0t: %s is %016h, expected %016h",
				$time, what, got, exp));
		end
	endtask

	task automatic compare_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			stop_with_failure($sformatf("FAIL %0t: %s is %b, expected %b",
				$time, what, got, exp));
		end
	endtask

	task automatic compare_latency(input longint got, input longint exp, input string what);
		if (got != exp) begin
			stop_with_failure($sformatf("FAIL %0t: %s took %0d cycles, expected %0d",
				$time, what, got, exp));
		end
	endtask

	task automatic load_stimulus(output int count);
		int                 fd;
		int                 n;
		bit                 reading;
		string              kind;
		string              sel;
		logic [31:0]        v0;
		logic [31:0]        v1;
		logic [31:0]        v2;
		logic [31:0]        v3;
		logic [31:0]        v4;
		logic [31:0]        v5;
		logic [8*160-1:0]   rest;
		count = 0;
		fd = $fopen("dv/mdu_stim.txt", "r");
		if (fd == 0) begin
			stop_with_failure("cannot open dv/mdu_stim.txt");
		end
		reading = 1'b1;
		while (reading) begin
			n = $fscanf(fd, "%s", kind);
			if (n != 1) begin
				reading = 1'b0;
			end else if (kind == "#") begin
				n = $fgets(rest, fd);  // rest of a comment line
			end else if (kind == "issue") begin
				n = $fscanf(fd, "%h %h %h %h %h %h", v0, v1, v2, v3, v4, v5);
				if (n != 6) stop_with_failure("malformed issue record in stimulus file");
				kind_q.push_back(kind);
				f0_q.push_back(v0);
				f1_q.push_back(v1);
				f2_q.push_back(v2);
				f3_q.push_back(v3);
				f4_q.push_back(v4);
				f5_q.push_back(v5);
				count++;
			end else if (kind == "move" || kind == "check") begin
				if (kind == "move") begin
					n = $fscanf(fd, "%s %h", sel, v1);
					v0 = (sel == "hi") ? 32'd1 : 32'd0;
				end else begin
					n = $fscanf(fd, "%h %h", v0, v1);
				end
				if (n != 2) stop_with_failure("malformed move or check record");
				kind_q.push_back(kind);
				f0_q.push_back(v0);
				f1_q.push_back(v1);
				f2_q.push_back('0);
				f3_q.push_back('0);
				f4_q.push_back('0);
				f5_q.push_back('0);
				count++;
			end else begin
				stop_with_failure({"unknown record kind in stimulus file: ", kind});
			end
		end
		$fclose(fd);
	endtask

	// drop the issue lines and wait for the pipe to drain
	task automatic settle();
		@(posedge clk);
		start <= 1'b0;
		kill  <= 1'b0;
		@(posedge clk);
		while (busy) @(posedge clk);
	endtask

	task automatic issue_op(input mdu_op_t o, input word_t x, input word_t y,
		input logic k, input logic chain, input word_t exp_mul);
		int gap;
		gap = chain ? 0 : ($random(seed) & 3);
		repeat (gap) begin
			@(posedge clk);
			start <= 1'b0;
		end
		@(posedge clk);
		start <= 1'b1;
		kill  <= k;
		op    <= o;
		a     <= x;
		b     <= y;
		if (!k) begin
			exp_op_q.push_back(o);
			exp_mul_q.push_back(exp_mul);
			exp_cyc_q.push_back(cyc + 1);  // accepted on the next edge
		end
	endtask

	task automatic move_to_hilo(input logic to_hi, input word_t value);
		settle();
		@(posedge clk);
		hilo_wr    <= 1'b1;
		hilo_wr_hi <= to_hi;
		wdata      <= value;
		@(posedge clk);
		hilo_wr    <= 1'b0;
	endtask

	task automatic verify_hilo(input dword_t exp);
		dword_t got;
		settle();
		@(posedge clk);
		rd_hi <= 1'b1;
		@(posedge clk);
		got[PROD_W-1:XLEN] = hilo_out;
		rd_hi <= 1'b0;
		@(posedge clk);
		got[XLEN-1:0] = hilo_out;
		compare_hilo(got, exp, "hi/lo");
	endtask

	always @(posedge clk) begin : done_monitor
		mdu_op_t op_exp;
		word_t   mul_exp;
		longint  cyc_acc;
		if (rst && done) begin
			if (exp_op_q.size() == 0) begin
				stop_with_failure("done pulse arrived with no issue in flight");
			end else begin
				op_exp  = exp_op_q.pop_front();
				mul_exp = exp_mul_q.pop_front();
				cyc_acc = exp_cyc_q.pop_front();
				compare_flag(busy, 1'b1, "busy during done");
				compare_latency(cyc - cyc_acc, LATENCY, "issue to done");
				if (op_exp == OP_MUL) compare_word(mul_out, mul_exp, "mul_out");
			end
		end
	end

	initial begin : watchdog
		wait (wd_limit_ns > 0);
		#(wd_limit_ns);
		stop_with_failure("watchdog timeout, done pulses missing");
	end

	initial begin : main
		int n_rec;
		rst        = 1'b0;
		start      = 1'b0;
		kill       = 1'b0;
		op         = OP_MULT;
		a          = '0;
		b          = '0;
		hilo_wr    = 1'b0;
		hilo_wr_hi = 1'b0;
		wdata      = '0;
		rd_hi      = 1'b0;
		load_stimulus(n_rec);
		wd_limit_ns = longint'(n_rec) * (LATENCY + 8) * 8 + 20 * 8;  // plus reset
		repeat (10) @(posedge clk);
		rst <= 1'b1;
		@(posedge clk);
		compare_flag(busy, 1'b0, "busy after reset");
		for (int i = 0; i < kind_q.size(); i++) begin
			if (kind_q[i] == "issue") begin
				issue_op(mdu_op_t'(f0_q[i][3:0]), f1_q[i], f2_q[i], f3_q[i][0],
					f4_q[i][0], f5_q[i]);
			end else if (kind_q[i] == "move") begin
				move_to_hilo(f0_q[i][0], f1_q[i]);
			end else begin
				verify_hilo({f0_q[i], f1_q[i]});
			end
		end
		settle();
		if (exp_op_q.size() == 0) begin
			$display("sim passed");
			$finish;
		end else begin
			stop_with_failure($sformatf("%0d completions never arrived", exp_op_q.size()));
		end
	end

endmodule

`default_nettype wire

// ==== logic/mdu_hilo_acc.sv ====
`timescale 1ns/1ps
`default_nettype none

module mdu_hilo_acc
	import mdu_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  logic    in_valid,
	input  mdu_op_t in_op,
	input  dword_t  in_prod,
	input  logic    hilo_wr,
	input  logic    hilo_wr_hi,
	input  logic    rd_hi,
	input  word_t   wdata,
	output word_t   hilo_out,
	output word_t   mul_out,
	output logic    done
);

	dword_t hilo;       // {hi, lo}
	dword_t hilo_next;  // value left by a completing op
	logic   op_wr;      // op class writes hi/lo
	word_t  mul_q;
	logic   done_q;

	// load, accumulate or subtract, all modulo 2^64
	always_comb begin
		op_wr     = 1'b0;
		hilo_next = hilo;
		case (in_op)
			OP_MULT, OP_MULTU: begin
				op_wr     = 1'b1;
				hilo_next = in_prod;
			end
			OP_MADD, OP_MADDU: begin
				op_wr     = 1'b1;
				hilo_next = hilo + in_prod;
			end
			OP_MSUB, OP_MSUBU: begin
				op_wr     = 1'b1;
				hilo_next = hilo - in_prod;
			end
			default: begin
				// mul and unused codes leave hi/lo alone
				op_wr     = 1'b0;
				hilo_next = hilo;
			end
		endcase
	end

	// a completion beats a move in the same cycle
	// a mul completion does not write hi/lo, so a move still lands then
	always_ff @(posedge clk) begin
		if (!rst) begin
			hilo <= '0;
		end else if (in_valid && op_wr) begin
			hilo <= hilo_next;
		end else if (hilo_wr) begin
			if (hilo_wr_hi) begin
				hilo[PROD_W-1:XLEN] <= wdata;  // mthi
			end else begin
				hilo[XLEN-1:0] <= wdata;       // mtlo
			end
		end
	end

	// mul result holds until the next mul completes
	always_ff @(posedge clk) begin
		if (!rst) begin
			mul_q <= '0;
		end else if (in_valid && in_op == OP_MUL) begin
			mul_q <= in_prod[XLEN-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			done_q <= 1'b0;
		end else begin
			done_q <= in_valid;  // one pulse per completion
		end
	end

	assign hilo_out = rd_hi ? hilo[PROD_W-1:XLEN] : hilo[XLEN-1:0];
	assign mul_out  = mul_q;
	assign done     = done_q;

endmodule

`default_nettype wire

// ==== logic/mdu_operand_prep.sv ====
`timescale 1ns/1ps
`default_nettype none

module mdu_operand_prep
	import mdu_pkg::*;
#(
	parameter int STAGES = MDU_STAGES_DEFAULT
) (
	input  logic    clk,
	input  logic    rst,
	input  logic    start,
	input  logic    kill,
	input  mdu_op_t op,
	input  word_t   a,
	input  word_t   b,
	output logic    out_valid,
	output mdu_op_t out_op,
	output dword_t  out_mcand,
	output dword_t  out_mplier,
	output dword_t  out_acc
);

	logic   accept;     // issue taken this edge
	logic   op_signed;
	dword_t a_ext;
	dword_t b_ext;

	// the slices must tile the 64 bit multiplier exactly
	if (!(STAGES == 2 || STAGES == 4 || STAGES == 8)) begin : g_bad_depth
		$error("mdu_operand_prep: STAGES must be 2, 4 or 8");
	end

	// a killed issue never enters the pipe
	assign accept = start & ~kill;

	always_comb begin
		case (op)
			OP_MULT, OP_MADD, OP_MSUB, OP_MUL: op_signed = 1'b1;
			OP_MULTU, OP_MADDU, OP_MSUBU:      op_signed = 1'b0;
			default:                           op_signed = 1'b0;
		endcase
	end

	// extend to full product width, the low 64 bits of the product are then
	// right for both signed and unsigned operands
	assign a_ext = {{XLEN{op_signed & a[XLEN-1]}}, a};
	assign b_ext = {{XLEN{op_signed & b[XLEN-1]}}, b};

	always_ff @(posedge clk) begin
		if (!rst) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= accept;
		end
	end

	// payload only moves on an accepted issue
	always_ff @(posedge clk) begin
		if (accept) begin
			out_op     <= op;
			out_mcand  <= a_ext;
			out_mplier <= b_ext;
			out_acc    <= '0;  // partial sum starts empty
		end
	end

endmodule

`default_nettype wire

// ==== logic/mdu_pkg.sv ====
`default_nettype none

package mdu_pkg;

	// operand and result widths
	localparam int XLEN   = 32;
	localparam int PROD_W = 2 * XLEN;  // hi and lo together

	// partial-product stages between the operand register and hi/lo
	// the top level accepts 2, 4 or 8
	localparam int MDU_STAGES_DEFAULT = 4;

	typedef logic [XLEN-1:0]   word_t;
	typedef logic [PROD_W-1:0] dword_t;

	// encoding as sent by the cpu decoder
	// signedness goes by mnemonic: the u forms are unsigned, the rest signed
	// codes 0010/0011 were the divider and are not used here
	typedef enum logic [3:0] {
		OP_MULT  = 4'b0000,  // hi/lo = a * b, signed
		OP_MULTU = 4'b0001,  // hi/lo = a * b, unsigned
		OP_MADDU = 4'b0100,  // hi/lo += a * b, unsigned
		OP_MADD  = 4'b0101,  // hi/lo += a * b, signed
		OP_MSUB  = 4'b0110,  // hi/lo -= a * b, signed
		OP_MSUBU = 4'b0111,  // hi/lo -= a * b, unsigned
		OP_MUL   = 4'b1000   // rd = low word of a * b, hi/lo untouched
	} mdu_op_t;

endpackage

`default_nettype wire

// ==== logic/mdu_pp_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module mdu_pp_stage
	import mdu_pkg::*;
#(
	parameter int BITS_PER_STAGE = PROD_W / MDU_STAGES_DEFAULT
) (
	input  logic    clk,
	input  logic    rst,
	input  logic    in_valid,
	input  mdu_op_t in_op,
	input  dword_t  in_mcand,
	input  dword_t  in_mplier,
	input  dword_t  in_acc,
	output logic    out_valid,
	output mdu_op_t out_op,
	output dword_t  out_mcand,
	output dword_t  out_mplier,
	output dword_t  out_acc
);

	dword_t pp [BITS_PER_STAGE];  // gated, shifted multiplicands
	dword_t sum;

	// one row per multiplier bit of this slice
	for (genvar j = 0; j < BITS_PER_STAGE; j++) begin : g_row
		assign pp[j] = in_mplier[j] ? (in_mcand << j) : '0;
	end

	// adder tree left to synthesis
	always_comb begin
		sum = in_acc;
		for (int j = 0; j < BITS_PER_STAGE; j++) begin
			sum = sum + pp[j];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
		end
	end

	// the next stage sees the following slice in the low bits of the multiplier
	always_ff @(posedge clk) begin
		if (in_valid) begin
			out_op     <= in_op;
			out_acc    <= sum;
			out_mcand  <= in_mcand << BITS_PER_STAGE;
			out_mplier <= in_mplier >> BITS_PER_STAGE;
		end
	end

endmodule

`default_nettype wire

// ==== logic/mdu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mdu_top
	import mdu_pkg::*;
#(
	parameter int STAGES = MDU_STAGES_DEFAULT
) (
	input  logic    clk,
	input  logic    rst,
	input  logic    start,
	input  logic    kill,
	input  mdu_op_t op,
	input  word_t   a,
	input  word_t   b,
	input  logic    hilo_wr,
	input  logic    hilo_wr_hi,
	input  word_t   wdata,
	input  logic    rd_hi,
	output word_t   hilo_out,
	output word_t   mul_out,
	output logic    done,
	output logic    busy
);

	localparam int BITS_PER_STAGE = PROD_W / STAGES;

	// chain slot i feeds stage i
	// slot STAGES is the last stage output and feeds hi/lo
	logic [STAGES:0] vld;
	mdu_op_t         op_c   [STAGES+1];
	dword_t          mcand  [STAGES+1];
	dword_t          mplier [STAGES+1];
	dword_t          acc    [STAGES+1];

	mdu_operand_prep #(
		.STAGES(STAGES)
	) u_prep (
		.clk        (clk),
		.rst        (rst),
		.start      (start),
		.kill       (kill),
		.op         (op),
		.a          (a),
		.b          (b),
		.out_valid  (vld[0]),
		.out_op     (op_c[0]),
		.out_mcand  (mcand[0]),
		.out_mplier (mplier[0]),
		.out_acc    (acc[0])
	);

	for (genvar i = 0; i < STAGES; i++) begin : g_stage
		mdu_pp_stage #(
			.BITS_PER_STAGE(BITS_PER_STAGE)
		) u_pp (
			.clk        (clk),
			.rst        (rst),
			.in_valid   (vld[i]),
			.in_op      (op_c[i]),
			.in_mcand   (mcand[i]),
			.in_mplier  (mplier[i]),
			.in_acc     (acc[i]),
			.out_valid  (vld[i+1]),
			.out_op     (op_c[i+1]),
			.out_mcand  (mcand[i+1]),
			.out_mplier (mplier[i+1]),
			.out_acc    (acc[i+1])
		);
	end

	// after the last slice the accumulator holds the full product
	mdu_hilo_acc u_acc (
		.clk        (clk),
		.rst        (rst),
		.in_valid   (vld[STAGES]),
		.in_op      (op_c[STAGES]),
		.in_prod    (acc[STAGES]),
		.hilo_wr    (hilo_wr),
		.hilo_wr_hi (hilo_wr_hi),
		.rd_hi      (rd_hi),
		.wdata      (wdata),
		.hilo_out   (hilo_out),
		.mul_out    (mul_out),
		.done       (done)
	);

	// anything in prep, in a stage, or completing this cycle
	assign busy = (|vld) | done;

endmodule

`default_nettype wire

// ==== sim.f ====
logic/mdu_pkg.sv
logic/mdu_operand_prep.sv
logic/mdu_pp_stage.sv
logic/mdu_hilo_acc.sv
logic/mdu_top.sv
dv/mdu_assertions.sv
dv/mdu_tb.sv
